// File: accel_pkg.sv
package accel_pkg;

	//////////////////////////////
	// Data path widths
	localparam int DATA_W = 8;
	localparam int ACC_W = 20;
	localparam int BIAS_W = 12;

	// Buffer geometry
	localparam int FEAT_DEPTH = 64;
	localparam int FEAT_ADDR_W = 6;
	localparam int TAPS = 3;
	localparam int KERNELS = 16;
	localparam int KIDX_W = 4;
	localparam int WGT_ADDR_W = 6; // kernel * TAPS + tap
	localparam int LEN_W = 7;

	//////////////////////////////
	// Stream credits
	localparam int LOAD_CREDITS = 2; // held by the sender after reset
	localparam int OUT_CREDITS = 4;
	localparam int OUT_CRED_W = 3;

	typedef logic [FEAT_ADDR_W-1:0] feat_addr_t;
	typedef logic [WGT_ADDR_W-1:0] wgt_addr_t;
	typedef logic [LEN_W-1:0] len_t;
	typedef logic [OUT_CRED_W-1:0] credit_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
	} load_word_t;

	typedef struct packed {
		logic signed [ACC_W-1:0] value;
		logic last;
	} result_t;

	typedef struct packed {
		logic [TAPS-1:0][DATA_W-1:0] tap; // tap 0 in the low byte
	} kernel_t;

	// One read or write step of the line counter
	typedef struct packed {
		feat_addr_t addr;
		logic valid;
		logic last;
	} scan_t;

endpackage

// File: inst_pkg.sv
package inst_pkg;

	localparam int INST_W = 32;
	localparam int SPARE_W = INST_W - 2 - accel_pkg::FEAT_ADDR_W - accel_pkg::LEN_W;

	typedef enum logic [1:0] {
		nop,
		load_weights,
		load_features,
		compute
	} opcode_t;

	//////////////////////////////
	// Load view, base is a weight or feature address
	typedef struct packed {
		opcode_t opcode;
		accel_pkg::feat_addr_t base;
		accel_pkg::len_t count;
		logic [SPARE_W-1:0] spare;
	} load_inst_t;

	// Compute view
	typedef struct packed {
		opcode_t opcode;
		logic [accel_pkg::KIDX_W-1:0] kernel;
		accel_pkg::feat_addr_t start;
		accel_pkg::len_t len;
		logic pool;
		logic [accel_pkg::BIAS_W-1:0] bias;
	} compute_inst_t;

	// Opcode sits in the top two bits of both views
	typedef union packed {
		load_inst_t ld;
		compute_inst_t cmp;
	} inst_t;

endpackage

// File: layer_sequencer.sv
`timescale 1ns/1ns

module layer_sequencer (
	input  logic                         clk,
	input  logic                         reset,
	input  inst_pkg::inst_t              instruction,
	input  logic                         inst_empty,
	input  logic                         count_last,
	input  logic                         line_done,
	output logic                         inst_req,
	output logic                         busy,
	output logic                         count_start,
	output accel_pkg::feat_addr_t        count_base,
	output accel_pkg::len_t              count_len,
	output logic                         wgt_sel,
	output logic                         feat_sel,
	output logic                         scan_sel,
	output logic [accel_pkg::KIDX_W-1:0] kernel_idx,
	output logic [accel_pkg::BIAS_W-1:0] bias,
	output logic                         pool
);

	typedef enum logic [2:0] {
		idle,
		fetch,
		decode,
		load,
		compute
	} state_t;

	state_t state;
	inst_pkg::inst_t inst_q;
	inst_pkg::opcode_t opcode;
	logic is_compute;

	assign opcode = inst_q.ld.opcode; // same bits in both views
	assign is_compute = opcode == inst_pkg::compute;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle: if (!inst_empty) state <= fetch;
				fetch: state <= decode;
				decode: begin
					if (opcode == inst_pkg::nop || count_len == '0) begin
						state <= idle;
					end else if (is_compute) begin
						state <= compute;
					end else begin
						state <= load;
					end
				end
				load: if (count_last) state <= idle;
				compute: if (line_done) state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// FIFO word is valid the cycle after the request
	always_ff @(posedge clk) begin
		if (state == fetch) begin
			inst_q <= instruction;
		end
	end

	assign inst_req = state == idle && !inst_empty;
	assign busy = state != idle;

	assign count_start = state == decode && opcode != inst_pkg::nop;
	assign count_base = is_compute ? inst_q.cmp.start : inst_q.ld.base;
	assign count_len = is_compute ? inst_q.cmp.len : inst_q.ld.count;

	// Who owns the counter address
	assign wgt_sel = state == load && opcode == inst_pkg::load_weights;
	assign feat_sel = state == load && opcode == inst_pkg::load_features;
	assign scan_sel = state == compute;

	// Held in inst_q for the whole compute
	assign kernel_idx = inst_q.cmp.kernel;
	assign bias = inst_q.cmp.bias;
	assign pool = inst_q.cmp.pool;

endmodule

// File: line_counter.sv
`timescale 1ns/1ns

module line_counter (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,
	input  accel_pkg::feat_addr_t base,
	input  accel_pkg::len_t       len,
	input  logic                  step,
	output accel_pkg::scan_t      scan,
	output logic                  last,
	output logic                  credit
);

	accel_pkg::feat_addr_t addr;
	accel_pkg::len_t remaining;
	logic active;
	logic fire;

	assign fire = step && active;

	always_ff @(posedge clk) begin
		if (reset) begin
			addr <= '0;
			remaining <= '0;
			active <= 1'b0;
			credit <= 1'b0;
		end else begin
			credit <= fire; // one credit back per accepted word
			if (start) begin
				addr <= base;
				remaining <= len;
				active <= len != '0;
			end else if (fire) begin
				addr <= addr + accel_pkg::feat_addr_t'(1);
				remaining <= remaining - accel_pkg::len_t'(1);
				active <= !last;
			end
		end
	end

	assign scan.addr = addr;
	assign scan.valid = fire;
	assign scan.last = remaining == accel_pkg::len_t'(1);

	assign last = fire && scan.last; // final item of the run

endmodule

// File: weight_buffer.sv
`timescale 1ns/1ns

module weight_buffer (
	input  logic                         clk,
	input  logic                         wr_en,
	input  accel_pkg::wgt_addr_t         wr_addr,
	input  logic [accel_pkg::DATA_W-1:0] wr_data,
	input  logic [accel_pkg::KIDX_W-1:0] kernel_idx,
	output accel_pkg::kernel_t           taps
);

	logic [accel_pkg::DATA_W-1:0] mem [accel_pkg::KERNELS * accel_pkg::TAPS];
	accel_pkg::wgt_addr_t base;

	// First tap of the selected kernel
	assign base = accel_pkg::wgt_addr_t'(kernel_idx) * accel_pkg::wgt_addr_t'(accel_pkg::TAPS);

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		for (int t = 0; t < accel_pkg::TAPS; t++) begin
			taps.tap[t] <= mem[base + accel_pkg::wgt_addr_t'(t)];
		end
	end

endmodule

// File: feature_buffer.sv
`timescale 1ns/1ns

module feature_buffer (
	input  logic                         clk,
	input  logic                         wr_en,
	input  accel_pkg::feat_addr_t        wr_addr,
	input  logic [accel_pkg::DATA_W-1:0] wr_data,
	input  accel_pkg::scan_t             rd,
	output logic [accel_pkg::DATA_W-1:0] rd_data,
	output logic                         rd_valid,
	output logic                         rd_last
);

	logic [accel_pkg::DATA_W-1:0] mem [accel_pkg::FEAT_DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd.addr];
		// Flags travel with the data
		rd_valid <= rd.valid;
		rd_last <= rd.last;
	end

endmodule

// File: conv_pe.sv
`timescale 1ns/1ns

module conv_pe (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [accel_pkg::DATA_W-1:0] feat_data,
	input  logic                         feat_valid,
	input  logic                         feat_last,
	input  accel_pkg::kernel_t           taps,
	input  logic [accel_pkg::BIAS_W-1:0] bias,
	input  logic                         pool,
	input  logic                         start,
	input  logic                         result_credit,
	output logic                         ready,
	output logic                         result_valid,
	output accel_pkg::result_t           result,
	output logic                         line_done
);

	logic signed [accel_pkg::DATA_W-1:0] win [accel_pkg::TAPS]; // win[0] is oldest
	logic [1:0] fill;
	logic odd;
	logic win_done;
	logic reserve;
	accel_pkg::credit_t free;
	logic signed [accel_pkg::ACC_W-1:0] acc;

	logic a_valid;
	logic a_last;
	logic a_pair2;
	logic b_valid;
	logic b_last;
	logic b_pair2;
	logic signed [accel_pkg::ACC_W-1:0] sum_q;

	logic signed [accel_pkg::ACC_W-1:0] held;
	logic signed [accel_pkg::ACC_W-1:0] pair_max;
	logic signed [accel_pkg::ACC_W-1:0] pend_value;
	logic signed [accel_pkg::ACC_W-1:0] c_value;
	logic pend;
	logic c_valid;
	logic c_last;
	logic none_q;

	//////////////////////////////
	// Output credits

	assign win_done = feat_valid && fill == 2'd2;
	assign reserve = win_done && (odd || !pool); // a pool pair takes one credit

	// Next step may start one more window
	assign ready = free > accel_pkg::credit_t'(reserve);

	always_ff @(posedge clk) begin
		if (reset) begin
			free <= accel_pkg::credit_t'(accel_pkg::OUT_CREDITS);
		end else begin
			free <= free - accel_pkg::credit_t'(reserve) + accel_pkg::credit_t'(result_credit);
		end
	end

	//////////////////////////////
	// Window and MAC

	always_comb begin
		acc = {{(accel_pkg::ACC_W - accel_pkg::BIAS_W){bias[accel_pkg::BIAS_W-1]}}, bias};
		for (int t = 0; t < accel_pkg::TAPS; t++) begin
			acc = acc + win[t] * $signed(taps.tap[t]);
		end
	end

	always_ff @(posedge clk) begin
		if (reset || start) begin
			fill <= '0;
			odd <= 1'b0;
			a_valid <= 1'b0;
			b_valid <= 1'b0;
		end else begin
			a_valid <= win_done;
			b_valid <= a_valid;
			if (feat_valid && fill != 2'd2) begin
				fill <= fill + 2'd1;
			end
			if (win_done) begin
				odd <= !odd;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (feat_valid) begin
			win[0] <= win[1];
			win[1] <= win[2];
			win[2] <= feat_data;
		end
		a_last <= feat_last;
		a_pair2 <= odd;
		sum_q <= acc; // unpooled result
		b_last <= a_last;
		b_pair2 <= a_pair2;
	end

	//////////////////////////////
	// Pooling
	// A finished pair waits for the next window to learn if it ends the line

	assign pair_max = (sum_q > held) ? sum_q : held;

	always_ff @(posedge clk) begin
		if (reset || start) begin
			c_valid <= 1'b0;
			pend <= 1'b0;
			none_q <= 1'b0;
		end else begin
			c_valid <= 1'b0;
			none_q <= feat_valid && feat_last && fill != 2'd2; // line too short
			if (pool && b_valid) begin
				if (!b_pair2) begin
					if (pend) begin
						c_valid <= 1'b1;
						pend <= 1'b0;
					end else if (b_last) begin
						none_q <= 1'b1; // lone window dropped
					end
				end else if (b_last) begin
					c_valid <= 1'b1;
				end else begin
					pend <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pool && b_valid) begin
			c_last <= b_last;
			if (!b_pair2) begin
				held <= sum_q;
				c_value <= pend_value;
			end else begin
				c_value <= pair_max;
				pend_value <= pair_max;
			end
		end
	end

	assign result_valid = pool ? c_valid : b_valid;
	assign result.value = pool ? c_value : sum_q;
	assign result.last = pool ? c_last : b_last;

	assign line_done = (result_valid && result.last) || none_q;

endmodule

// File: hwcnn_top.sv
`timescale 1ns/1ns

module hwcnn_top (
	input  logic                  clk,
	input  logic                  reset,
	input  inst_pkg::inst_t       instruction,
	input  logic                  inst_empty,
	output logic                  inst_req,
	input  logic                  load_valid,
	input  accel_pkg::load_word_t load_data,
	output logic                  load_credit,
	output logic                  result_valid,
	output accel_pkg::result_t    result,
	input  logic                  result_credit,
	output logic                  busy
);

	logic count_start;
	accel_pkg::feat_addr_t count_base;
	accel_pkg::len_t count_len;
	logic count_last;
	logic wgt_sel;
	logic feat_sel;
	logic scan_sel;
	logic [accel_pkg::KIDX_W-1:0] kernel_idx;
	logic [accel_pkg::BIAS_W-1:0] bias;
	logic pool;
	logic line_done;
	logic step;
	accel_pkg::scan_t scan;
	logic counter_credit;
	accel_pkg::kernel_t taps;
	logic [accel_pkg::DATA_W-1:0] feat_data;
	logic rd_valid;
	logic feat_valid;
	logic feat_last;
	logic ready;

	// Counter steps on inbound words for loads, on PE ready for compute
	assign step = scan_sel ? ready : load_valid;
	assign load_credit = counter_credit && !scan_sel;
	assign feat_valid = rd_valid && scan_sel;

	layer_sequencer u_seq (
		.clk(clk), .reset(reset),
		.instruction(instruction), .inst_empty(inst_empty), .inst_req(inst_req),
		.count_last(count_last), .line_done(line_done), .busy(busy),
		.count_start(count_start), .count_base(count_base), .count_len(count_len),
		.wgt_sel(wgt_sel), .feat_sel(feat_sel), .scan_sel(scan_sel),
		.kernel_idx(kernel_idx), .bias(bias), .pool(pool)
	);

	line_counter u_cnt (
		.clk(clk), .reset(reset),
		.start(count_start), .base(count_base), .len(count_len), .step(step),
		.scan(scan), .last(count_last), .credit(counter_credit)
	);

	weight_buffer u_wbuf (
		.clk(clk),
		.wr_en(scan.valid && wgt_sel), .wr_addr(scan.addr), .wr_data(load_data.data),
		.kernel_idx(kernel_idx), .taps(taps)
	);

	feature_buffer u_fbuf (
		.clk(clk),
		.wr_en(scan.valid && feat_sel), .wr_addr(scan.addr), .wr_data(load_data.data),
		.rd(scan), .rd_data(feat_data), .rd_valid(rd_valid), .rd_last(feat_last)
	);

	conv_pe u_pe (
		.clk(clk), .reset(reset),
		.feat_data(feat_data), .feat_valid(feat_valid), .feat_last(feat_last),
		.taps(taps), .bias(bias), .pool(pool), .start(count_start),
		.result_credit(result_credit), .ready(ready),
		.result_valid(result_valid), .result(result), .line_done(line_done)
	);

endmodule

// File: tb_tests.svh
//////////////////////////////
// Reference model and instruction words

function automatic int random_bias();
	return int'($urandom_range(4095, 0)) - 2048;
endfunction

// Window starts at feature address start, oldest feature meets tap 0
function automatic int window_sum(input int kernel, input int start, input int bias);
	int sum;
	sum = bias;
	for (int t = 0; t < accel_pkg::TAPS; t++) begin
		sum += int'(feat_model[(start + t) % accel_pkg::FEAT_DEPTH])
			* int'(wgt_model[kernel * accel_pkg::TAPS + t]);
	end
	return sum;
endfunction

function automatic void expect_line(input int kernel, input int start, input int len,
	input logic pool, input int bias);
	int sums[$];
	int n;
	for (int i = 0; i + 2 < len; i++) begin
		sums.push_back(window_sum(kernel, start + i, bias));
	end
	n = pool ? sums.size() / 2 : sums.size(); // odd window left over is dropped
	for (int j = 0; j < n; j++) begin
		if (pool) begin
			exp_value.push_back(sums[2*j] > sums[2*j+1] ? sums[2*j] : sums[2*j+1]);
		end else begin
			exp_value.push_back(sums[j]);
		end
		exp_last.push_back(j == n - 1);
	end
endfunction

function automatic inst_pkg::inst_t load_inst(input inst_pkg::opcode_t op, input int base,
	input int count);
	inst_pkg::inst_t w;
	w = '0;
	w.ld.opcode = op;
	w.ld.base = base[accel_pkg::FEAT_ADDR_W-1:0];
	w.ld.count = count[accel_pkg::LEN_W-1:0];
	return w;
endfunction

function automatic inst_pkg::inst_t compute_inst(input int kernel, input int start,
	input int len, input logic pool, input int bias);
	inst_pkg::inst_t w;
	w.cmp.opcode = inst_pkg::compute;
	w.cmp.kernel = kernel[accel_pkg::KIDX_W-1:0];
	w.cmp.start = start[accel_pkg::FEAT_ADDR_W-1:0];
	w.cmp.len = len[accel_pkg::LEN_W-1:0];
	w.cmp.pool = pool;
	w.cmp.bias = bias[accel_pkg::BIAS_W-1:0];
	return w;
endfunction

task automatic wait_results(input int count);
	int cycles;
	cycles = 0;
	while (got_value.size() < count && cycles < WAIT_LIMIT) begin
		@(posedge clk);
		cycles++;
	end
	if (got_value.size() < count) begin
		$display("%0t ns: timed out with %0d of %0d results", $time, got_value.size(), count);
		errors++;
	end
endtask

task automatic compare_results();
	int n;
	repeat (4) @(posedge clk); // Catch stray results
	n = got_value.size() < exp_value.size() ? got_value.size() : exp_value.size();
	if (got_value.size() != exp_value.size()) begin
		$display("Mismatch at %0t ns: result count = %0d, expected %0d",
			$time, got_value.size(), exp_value.size());
		errors++;
	end
	for (int i = 0; i < n; i++) begin
		if (got_value[i] != exp_value[i]) begin
			$display("Mismatch at %0t ns: result.value[%0d] = %0d, expected %0d",
				$time, i, got_value[i], exp_value[i]);
			errors++;
		end
		if (got_last[i] !== exp_last[i]) begin
			$display("Mismatch at %0t ns: result.last[%0d] = %0b, expected %0b",
				$time, i, got_last[i], exp_last[i]);
			errors++;
		end
	end
	got_value.delete();
	got_last.delete();
	exp_value.delete();
	exp_last.delete();
endtask

task automatic run_line(input int kernel, input int start, input int len, input logic pool,
	input int bias);
	expect_line(kernel, start, len, pool, bias);
	inst_fifo.push_back(compute_inst(kernel, start, len, pool, bias));
	wait_results(exp_value.size());
	wait_busy(1'b0);
	compare_results();
endtask

//////////////////////////////
// Directed tests

task automatic check_reset_idle();
	int err0;
	err0 = errors;
	@(posedge clk);
	check_bit("inst_req", inst_req, 1'b0);
	check_bit("load_credit", load_credit, 1'b0);
	check_bit("result_valid", result_valid, 1'b0);
	check_bit("busy", busy, 1'b0);
	repeat (20) begin
		@(posedge clk);
		check_bit("busy", busy, 1'b0); // FIFO stays empty
	end
	report_test("reset and idle", err0);
endtask

task automatic load_buffers();
	int err0;
	byte words[$];
	err0 = errors;
	for (int i = 0; i < accel_pkg::KERNELS * accel_pkg::TAPS; i++) begin
		words.push_back(byte'($urandom_range(255, 0)));
		wgt_model[i] = words[i];
	end
	inst_fifo.push_back(load_inst(inst_pkg::load_weights, 0, words.size()));
	send_words(words);
	wait_busy(1'b0);
	words.delete();
	for (int i = 0; i < accel_pkg::FEAT_DEPTH; i++) begin
		words.push_back(byte'($urandom_range(255, 0)));
		feat_model[i] = words[i];
	end
	inst_fifo.push_back(load_inst(inst_pkg::load_features, 0, words.size()));
	send_words(words);
	wait_busy(1'b0);
	report_test("weight and feature loads", err0);
endtask

task automatic unpooled_line();
	int err0;
	err0 = errors;
	run_line(int'($urandom_range(15, 0)), int'($urandom_range(40, 0)), 20, 1'b0, random_bias());
	report_test("unpooled compute", err0);
endtask

task automatic pooled_lines();
	int err0;
	err0 = errors;
	run_line(int'($urandom_range(15, 0)), 3, 13, 1'b1, random_bias()); // 11 windows
	run_line(int'($urandom_range(15, 0)), 30, 10, 1'b1, random_bias());
	report_test("pooled compute", err0);
endtask

task automatic credit_backpressure();
	int err0;
	int kernel;
	int bias;
	err0 = errors;
	kernel = int'($urandom_range(15, 0));
	bias = random_bias();
	hold_credits <= 1'b1;
	expect_line(kernel, 4, 30, 1'b0, bias);
	inst_fifo.push_back(compute_inst(kernel, 4, 30, 1'b0, bias));
	repeat (STALL_CYCLES) @(posedge clk);
	if (got_value.size() > accel_pkg::OUT_CREDITS) begin
		$display("%0t ns: %0d results arrived while credits were withheld",
			$time, got_value.size());
		errors++;
	end
	random_gap <= 1'b1; // Credits come back with random delays
	hold_credits <= 1'b0;
	wait_results(exp_value.size());
	wait_busy(1'b0);
	compare_results();
	random_gap <= 1'b0;
	report_test("credit back-pressure", err0);
endtask

task automatic back_to_back_instructions();
	int err0;
	int bias5;
	int bias0;
	byte words[$];
	err0 = errors;
	bias5 = random_bias();
	bias0 = random_bias();
	for (int i = 0; i < 40; i++) begin
		words.push_back(byte'($urandom_range(255, 0)));
		feat_model[i] = words[i];
	end
	expect_line(5, 2, 16, 1'b0, bias5);
	expect_line(0, 10, 15, 1'b1, bias0);
	inst_fifo.push_back(load_inst(inst_pkg::load_features, 0, words.size()));
	inst_fifo.push_back(compute_inst(5, 2, 16, 1'b0, bias5));
	inst_fifo.push_back(compute_inst(0, 10, 15, 1'b1, bias0));
	send_words(words);
	wait_results(exp_value.size());
	wait_busy(1'b0);
	compare_results();
	check_bit("busy", busy, 1'b0);
	report_test("back-to-back instructions", err0);
endtask

// File: tb_hwcnn.sv
`timescale 1ns/1ns

module tb_hwcnn;

	localparam int CLK_HALF = 4;
	localparam int CLK_PERIOD = 2 * CLK_HALF;
	localparam int RESET_CYCLES = 16;
	localparam int WAIT_LIMIT = 1000; // cycles for any single wait
	localparam int STALL_CYCLES = 60;

	// Expected length of each test in cycles
	localparam int RESET_TEST_CYC = 40;
	localparam int LOAD_TEST_CYC = 250;
	localparam int UNPOOLED_TEST_CYC = 100;
	localparam int POOLED_TEST_CYC = 150;
	localparam int STALL_TEST_CYC = 350;
	localparam int CHAIN_TEST_CYC = 250;
	localparam int WATCHDOG_NS = 4 * CLK_PERIOD * (RESET_CYCLES + RESET_TEST_CYC
		+ LOAD_TEST_CYC + UNPOOLED_TEST_CYC + POOLED_TEST_CYC + STALL_TEST_CYC
		+ CHAIN_TEST_CYC);

	logic clk = 1'b0;
	logic reset = 1'b1;
	inst_pkg::inst_t instruction = '0;
	logic inst_empty = 1'b1;
	logic inst_req;
	logic load_valid = 1'b0;
	accel_pkg::load_word_t load_data = '0;
	logic load_credit;
	logic result_valid;
	accel_pkg::result_t result;
	logic result_credit = 1'b0;
	logic busy;

	inst_pkg::inst_t inst_fifo[$];
	byte wgt_model [accel_pkg::KERNELS * accel_pkg::TAPS];
	byte feat_model [accel_pkg::FEAT_DEPTH];
	int got_value[$];
	logic got_last[$];
	int exp_value[$];
	logic exp_last[$];
	int outstanding = 0; // results taken, credit not yet sent back
	int credit_gap = 0;
	logic hold_credits = 1'b0;
	logic random_gap = 1'b0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	always #CLK_HALF clk = ~clk;

	hwcnn_top DUT (
		.clk(clk), .reset(reset),
		.instruction(instruction), .inst_empty(inst_empty), .inst_req(inst_req),
		.load_valid(load_valid), .load_data(load_data), .load_credit(load_credit),
		.result_valid(result_valid), .result(result), .result_credit(result_credit),
		.busy(busy)
	);

	//////////////////////////////
	// Instruction FIFO, word shows up the cycle after the request
	always @(posedge clk) begin
		if (inst_req) begin
			if (inst_fifo.size() > 0) begin
				instruction <= inst_fifo.pop_front();
			end else begin
				$display("%0t ns: instruction requested from an empty FIFO", $time);
				errors++;
			end
		end
		inst_empty <= inst_fifo.size() == 0;
	end

	// Result receiver
	always @(posedge clk) begin
		result_credit <= 1'b0;
		if (result_valid) begin
			got_value.push_back(int'($signed(result.value)));
			got_last.push_back(result.last);
			outstanding = outstanding + 1;
			if (outstanding > accel_pkg::OUT_CREDITS) begin
				$display("%0t ns: %0d results outstanding with only %0d credits",
					$time, outstanding, accel_pkg::OUT_CREDITS);
				errors++;
			end
		end
		if (credit_gap > 0) begin
			credit_gap = credit_gap - 1;
		end else if (!hold_credits && outstanding > 0) begin
			result_credit <= 1'b1;
			outstanding = outstanding - 1;
			credit_gap = random_gap ? int'($urandom_range(5, 0)) : 0;
		end
	end

	`include "tb_tests.svh"

	// Sends one load's words under credit control, then waits for every credit
	task automatic send_words(input byte words[$]);
		int credits;
		int sent;
		int returned;
		int cycles;
		credits = accel_pkg::LOAD_CREDITS;
		sent = 0;
		returned = 0;
		cycles = 0;
		wait_busy(1'b1);
		while (returned < words.size() && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			cycles++;
			if (load_credit) begin
				credits++;
				returned++;
			end
			if (credits > accel_pkg::LOAD_CREDITS) begin
				$display("%0t ns: load credit came back with no word outstanding", $time);
				errors++;
			end
			if (credits > 0 && sent < words.size()) begin
				load_valid <= 1'b1;
				load_data.data <= words[sent];
				credits--;
				sent++;
			end else begin
				load_valid <= 1'b0;
			end
		end
		if (returned != words.size()) begin
			$display("%0t ns: %0d load credits returned for %0d words",
				$time, returned, words.size());
			errors++;
		end
		@(posedge clk);
		if (load_credit) begin
			$display("%0t ns: extra load credit after the load finished", $time);
			errors++;
		end
	endtask

	task automatic wait_busy(input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (busy !== level && cycles < WAIT_LIMIT);
		if (busy !== level) begin
			$display("%0t ns: timed out waiting for busy to become %0b", $time, level);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("Mismatch at %0t ns: %s = %0b, expected %0b", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_at_start);
		tests_run++;
		if (errors > err_at_start) begin
			tests_failed++;
			$display("%0t ns: %s failed with %0d errors", $time, name, errors - err_at_start);
		end else begin
			$display("%0t ns: %s passed", $time, name);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		void'($urandom(17498));
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		check_reset_idle();
		load_buffers();
		unpooled_line();
		pooled_lines();
		credit_backpressure();
		back_to_back_instructions();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+.
accel_pkg.sv
inst_pkg.sv
layer_sequencer.sv
line_counter.sv
weight_buffer.sv
feature_buffer.sv
conv_pe.sv
hwcnn_top.sv
tb_hwcnn.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_hwcnn -f sources.f -o sim_hwcnn

sim_out=$(./obj_dir/sim_hwcnn)
echo "$sim_out"
echo "$sim_out" | grep -qx "=== PASS ==="
